// ==== design/pcs_block_pkg.sv ====
// 64b/66b coded block format shared by the receive AM lock stage.
// Holds the block widths, the sync header codes and a packed union that
// gives a block two views, the generic payload and the alignment marker
// fields. Modules import it inside their body and use scoped names in
// their port lists.

`default_nettype none

package pcs_block_pkg;

    localparam int NB_BLOCK   = 66;             // coded block width
    localparam int NB_SH      = 2;              // sync header width
    localparam int NB_PAYLOAD = NB_BLOCK - NB_SH;
    localparam int NB_BIP     = 8;              // bip3/bip7 field width

    localparam logic [NB_SH-1:0] SH_DATA = 2'b01;   // data block
    localparam logic [NB_SH-1:0] SH_CTRL = 2'b10;   // control block, carries AMs

    // generic view, header on top of the scrambled payload
    typedef struct packed {
        logic [NB_SH-1:0]      sh;
        logic [NB_PAYLOAD-1:0] payload;
    } pcs_raw_t;

    // alignment marker view, fields in transmit order from the msb down
    typedef struct packed {
        logic [NB_SH-1:0]  sh;
        logic [7:0]        m0;
        logic [7:0]        m1;
        logic [7:0]        m2;
        logic [NB_BIP-1:0] bip3;                // parity over the previous period
        logic [7:0]        m4;                  // m4..m6 are ~m0..~m2
        logic [7:0]        m5;
        logic [7:0]        m6;
        logic [NB_BIP-1:0] bip7;                // ~bip3 on the wire
    } pcs_am_t;

    typedef union packed {
        pcs_raw_t raw;
        pcs_am_t  am;
    } pcs_block_t;

endpackage

`default_nettype wire

// ==== design/am_lock_pkg.sv ====
// Lane alignment marker lock protocol constants.
// Marker table for the four lanes, marker period, lock FSM state codes
// and the widths of the thresholds and status counters. The period is cut
// down for simulation; a full-size lane uses 16384 blocks between markers.

`default_nettype none

package am_lock_pkg;

    localparam int N_LANES    = 4;
    localparam int NB_LANE_ID = 2;
    localparam int NB_AM      = 48;             // m0..m2 and m4..m6

    // 100G lane markers, each 24 bit code followed by its complement
    localparam logic [N_LANES-1:0][NB_AM-1:0] AM_TABLE = {
        48'h4D957B_B26A84,                      // lane 3
        48'h594BE8_A6B417,                      // lane 2
        48'h9D718E_628E71,                      // lane 1
        48'hC16821_3E97DE                       // lane 0
    };

    localparam int NB_PERIOD = 3;
    localparam int AM_PERIOD = 8;               // blocks from marker to marker

    localparam int NB_THR    = 3;               // valid and invalid thresholds
    localparam int NB_ERR    = 16;              // bip3 error counter
    localparam int NB_RESYNC = 8;               // resync event counter

    // lock FSM encoding
    localparam int NB_STATE = 2;
    localparam logic [NB_STATE-1:0] ST_SEARCH = 2'b00;  // waiting for a candidate
    localparam logic [NB_STATE-1:0] ST_VERIFY = 2'b01;  // counting good markers
    localparam logic [NB_STATE-1:0] ST_LOCKED = 2'b10;  // tracking, counting misses

endpackage

`default_nettype wire

// ==== design/am_match_decoder.sv ====
// Alignment marker decoder for the receive lock stage.
// Compares the marker fields of a control block against all four lane
// markers in parallel, ignoring bit positions set in the compare mask.
// Purely combinational; the lowest matching lane wins.

`timescale 1ns/1ps
`default_nettype none

module am_match_decoder
(
    input  wire pcs_block_pkg::pcs_block_t          i_block,
    input  wire [am_lock_pkg::NB_AM-1:0]            i_compare_mask,
    output logic                                    o_match,
    output logic [am_lock_pkg::NB_LANE_ID-1:0]      o_match_lane
);

    import pcs_block_pkg::*;
    import am_lock_pkg::*;

    logic [NB_AM-1:0]   am_value;                   // marker bytes without bip
    logic               is_ctrl;
    logic [N_LANES-1:0] lane_hit;

    assign am_value = {i_block.am.m0, i_block.am.m1, i_block.am.m2,
                       i_block.am.m4, i_block.am.m5, i_block.am.m6};

    assign is_ctrl = (i_block.am.sh == SH_CTRL);

    always_comb
    begin
        for (int k = 0; k < N_LANES; k++)
        begin
            // masked bits never count as a difference
            lane_hit[k] = is_ctrl &&
                          (((am_value ^ AM_TABLE[k]) & ~i_compare_mask) == '0);
        end
    end

    assign o_match = |lane_hit;

    // lowest lane has priority when a loose mask hits several
    always_comb
    begin
        o_match_lane = '0;
        for (int k = N_LANES - 1; k >= 0; k--)
        begin
            if (lane_hit[k])
            begin
                o_match_lane = NB_LANE_ID'(k);
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/am_lock_fsm.sv ====
// Alignment marker lock state machine.
// Takes the first matching marker as a candidate, then checks every
// AM_PERIOD-th valid block for the same lane. Enough good markers give
// lock; enough bad ones while locked drop it with a resync pulse.
// Lock state and lane are registered, the strobes are combinational
// and qualified by i_valid.

`timescale 1ns/1ps
`default_nettype none

module am_lock_fsm
(
    input  wire                                     i_clock,
    input  wire                                     i_reset,
    input  wire                                     i_valid,
    input  wire                                     i_block_lock,
    input  wire                                     i_match,
    input  wire [am_lock_pkg::NB_LANE_ID-1:0]       i_match_lane,
    input  wire [am_lock_pkg::NB_THR-1:0]           i_valid_thr,
    input  wire [am_lock_pkg::NB_THR-1:0]           i_invalid_thr,
    output logic                                    o_am_lock,
    output logic [am_lock_pkg::NB_LANE_ID-1:0]      o_lane_id,
    output logic                                    o_resync,
    output logic                                    o_am_pulse,
    output logic                                    o_search_start
);

    import am_lock_pkg::*;

    logic [NB_STATE-1:0]   state;
    logic [NB_STATE-1:0]   state_next;
    logic [NB_LANE_ID-1:0] lane;
    logic [NB_LANE_ID-1:0] lane_next;
    logic [NB_PERIOD-1:0]  timer;                   // valid blocks since last marker
    logic [NB_PERIOD-1:0]  timer_next;
    logic [NB_THR-1:0]     valid_cnt;
    logic [NB_THR-1:0]     valid_cnt_next;
    logic [NB_THR-1:0]     invalid_cnt;
    logic [NB_THR-1:0]     invalid_cnt_next;
    logic [NB_THR-1:0]     valid_inc;
    logic [NB_THR-1:0]     invalid_inc;
    logic                  expected;                // block sits on the marker slot
    logic                  same_lane;

    assign expected    = (timer == NB_PERIOD'(AM_PERIOD - 1));
    assign same_lane   = i_match && (i_match_lane == lane);
    assign valid_inc   = valid_cnt + 1'b1;
    assign invalid_inc = invalid_cnt + 1'b1;

    always_comb
    begin
        state_next       = state;
        lane_next        = lane;
        timer_next       = timer;
        valid_cnt_next   = valid_cnt;
        invalid_cnt_next = invalid_cnt;
        o_resync         = 1'b0;
        o_am_pulse       = 1'b0;
        o_search_start   = 1'b0;
        if (i_valid)
        begin
            if (!i_block_lock)
            begin
                state_next = ST_SEARCH;             // no alignment without block lock
                o_resync   = (state == ST_LOCKED);
            end
            else
            begin
                timer_next = expected ? '0 : timer + 1'b1;
                case (state)
                    ST_SEARCH:
                    begin
                        if (i_match)
                        begin
                            o_search_start = 1'b1;  // candidate marker
                            lane_next      = i_match_lane;
                            timer_next     = '0;
                            valid_cnt_next = NB_THR'(1);
                            state_next     = ST_VERIFY;
                        end
                    end
                    ST_VERIFY:
                    begin
                        if (expected && same_lane && (valid_inc >= i_valid_thr))
                        begin
                            state_next       = ST_LOCKED;
                            invalid_cnt_next = '0;
                            o_am_pulse       = 1'b1;    // lock completing marker
                        end
                        else if (expected && same_lane)
                        begin
                            valid_cnt_next = valid_inc;
                        end
                        else if (expected)
                        begin
                            state_next = ST_SEARCH; // candidate was false
                        end
                    end
                    ST_LOCKED:
                    begin
                        if (expected && same_lane)
                        begin
                            invalid_cnt_next = '0;
                            o_am_pulse       = 1'b1;
                        end
                        else if (expected && (invalid_inc >= i_invalid_thr))
                        begin
                            state_next = ST_SEARCH;
                            o_resync   = 1'b1;
                        end
                        else if (expected)
                        begin
                            invalid_cnt_next = invalid_inc;
                        end
                    end
                    default:
                    begin
                        state_next = ST_SEARCH;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state       <= ST_SEARCH;
            lane        <= '0;
            timer       <= '0;
            valid_cnt   <= '0;
            invalid_cnt <= '0;
        end
        else
        begin
            state       <= state_next;
            lane        <= lane_next;
            timer       <= timer_next;
            valid_cnt   <= valid_cnt_next;
            invalid_cnt <= invalid_cnt_next;
        end
    end

    assign o_am_lock = (state == ST_LOCKED);
    assign o_lane_id = lane;

endmodule

`default_nettype wire

// ==== design/bip_error_checker.sv ====
// BIP3 checker for the receive lock stage.
// Folds every valid block payload into an 8 bit running parity, bit i
// being the XOR of payload bits j with j mod 8 == i. At each accepted
// marker the carried bip3 is compared with the parity of the blocks since
// the previous marker, and mismatches are counted with saturation.
// A restart clears the parity and the count for a new lock attempt.

`timescale 1ns/1ps
`default_nettype none

module bip_error_checker
(
    input  wire                                 i_clock,
    input  wire                                 i_reset,
    input  wire                                 i_valid,
    input  wire pcs_block_pkg::pcs_block_t      i_block,
    input  wire                                 i_am_pulse,
    input  wire                                 i_restart,
    output logic [am_lock_pkg::NB_ERR-1:0]      o_error_count
);

    import pcs_block_pkg::*;
    import am_lock_pkg::*;

    logic [NB_BIP-1:0] fold;                        // parity of this block alone
    logic [NB_BIP-1:0] bip_acc;
    logic              bip_bad;

    // bit i of every payload byte lands on accumulator bit i
    always_comb
    begin
        fold = '0;
        for (int k = 0; k < NB_PAYLOAD / NB_BIP; k++)
        begin
            fold = fold ^ i_block.raw.payload[k*NB_BIP +: NB_BIP];
        end
    end

    assign bip_bad = (i_block.am.bip3 != bip_acc);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            bip_acc       <= '0;
            o_error_count <= '0;
        end
        else if (i_restart)
        begin
            bip_acc       <= '0;                    // new period starts after this block
            o_error_count <= '0;
        end
        else if (i_am_pulse)
        begin
            bip_acc <= '0;                          // marker itself not folded in
            if (bip_bad && (o_error_count != '1))
            begin
                o_error_count <= o_error_count + 1'b1;
            end
        end
        else if (i_valid)
        begin
            bip_acc <= bip_acc ^ fold;
        end
    end

endmodule

`default_nettype wire

// ==== design/am_lock_top.sv ====
// Top level of the single lane receive alignment marker lock stage.
// Decoder, lock FSM and BIP3 checker in a decode/execute/result chain,
// followed by one register stage for data, valid and the marker strobe.
// Also counts resync events. Thresholds and the compare mask are static
// settings driven from outside.

`timescale 1ns/1ps
`default_nettype none

module am_lock_top
(
    input  wire                                     i_clock,
    input  wire                                     i_reset,
    input  wire                                     i_valid,
    input  wire                                     i_block_lock,
    input  wire [pcs_block_pkg::NB_BLOCK-1:0]       i_data,
    input  wire [am_lock_pkg::NB_AM-1:0]            i_compare_mask,
    input  wire [am_lock_pkg::NB_THR-1:0]           i_valid_thr,
    input  wire [am_lock_pkg::NB_THR-1:0]           i_invalid_thr,
    output logic [pcs_block_pkg::NB_BLOCK-1:0]      o_data,
    output logic                                    o_valid,
    output logic                                    o_am_strobe,
    output logic                                    o_am_lock,
    output logic [am_lock_pkg::NB_LANE_ID-1:0]      o_lane_id,
    output logic                                    o_resync,
    output logic [am_lock_pkg::NB_RESYNC-1:0]       o_resync_count,
    output logic [am_lock_pkg::NB_ERR-1:0]          o_error_count
);

    import pcs_block_pkg::*;
    import am_lock_pkg::*;

    pcs_block_t          block;
    logic                match;
    logic [NB_LANE_ID-1:0] match_lane;
    logic                resync;
    logic                am_pulse;
    logic                search_start;

    assign block = i_data;

    am_match_decoder u_am_match_decoder
    (
        .i_block        (block),
        .i_compare_mask (i_compare_mask),
        .o_match        (match),
        .o_match_lane   (match_lane)
    );

    am_lock_fsm u_am_lock_fsm
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_block_lock   (i_block_lock),
        .i_match        (match),
        .i_match_lane   (match_lane),
        .i_valid_thr    (i_valid_thr),
        .i_invalid_thr  (i_invalid_thr),
        .o_am_lock      (o_am_lock),
        .o_lane_id      (o_lane_id),
        .o_resync       (resync),
        .o_am_pulse     (am_pulse),
        .o_search_start (search_start)
    );

    bip_error_checker u_bip_error_checker
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_block        (block),
        .i_am_pulse     (am_pulse),
        .i_restart      (resync | search_start),    // new lock attempt
        .o_error_count  (o_error_count)
    );

    always_ff @(posedge i_clock)
    begin
        o_data <= i_data;                           // datapath register
        if (i_reset)
        begin
            o_valid        <= 1'b0;
            o_am_strobe    <= 1'b0;
            o_resync       <= 1'b0;
            o_resync_count <= '0;
        end
        else
        begin
            o_valid     <= i_valid;
            o_am_strobe <= am_pulse;
            o_resync    <= resync;
            if (resync && (o_resync_count != '1))   // saturates
            begin
                o_resync_count <= o_resync_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/am_lock_asserts.sv ====
// Concurrent checks on the outputs of the AM lock top level.
// Bound into am_lock_top from the testbench. Every failure raises $error
// and bumps fail_count, which the testbench folds into its summary.

`timescale 1ns/1ps
`default_nettype none

module am_lock_asserts
(
    input wire                                  i_clock,
    input wire                                  i_reset,
    input wire                                  i_valid,
    input wire                                  i_am_strobe,
    input wire                                  i_am_lock,
    input wire [am_lock_pkg::NB_LANE_ID-1:0]    i_lane_id,
    input wire                                  i_resync
);

    int fail_count = 0;

    // a resync only ever follows a locked cycle
    resync_after_lock: assert property (@(posedge i_clock) disable iff (i_reset)
        i_resync |-> $past(i_am_lock))
    else
    begin
        fail_count++;
        $error("o_resync rose without o_am_lock on the cycle before");
    end

    lane_stable_in_lock: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_am_lock && $past(i_am_lock)) |-> $stable(i_lane_id))
    else
    begin
        fail_count++;
        $error("o_lane_id changed while o_am_lock was held");
    end

    strobe_needs_valid: assert property (@(posedge i_clock) disable iff (i_reset)
        i_am_strobe |-> i_valid)
    else
    begin
        fail_count++;
        $error("o_am_strobe high on a cycle without o_valid");
    end

endmodule

`default_nettype wire

// ==== dv/am_lock_tb.sv ====
// Testbench for the single lane AM lock stage.
// Plays back dv/am_lock_stim.hex, one line per run of identical cycles,
// and checks every output one cycle after the block that drives it.
// Idle payloads are random; marker bip3 fields are filled in from a
// running parity model kept here.

`timescale 1ns/1ps
`default_nettype none

module am_lock_tb;

    import pcs_block_pkg::*;
    import am_lock_pkg::*;

    localparam int CLOCK_HALF   = 20;
    localparam int CLOCK_PERIOD = 2 * CLOCK_HALF;
    localparam int RESET_CYCLES = 3;
    localparam int STIM_DEPTH   = 64;
    localparam int NB_STIM      = 168;

    localparam logic [3:0] MODE_IDLE   = 4'd1;      // random data block
    localparam logic [3:0] MODE_AM     = 4'd2;      // marker, correct bip3
    localparam logic [3:0] MODE_AM_BAD = 4'd3;      // marker, corrupted bip3
    localparam logic [NB_BIP-1:0] BIP_FLIP = 8'h5A;

    logic                  i_clock;
    logic                  i_reset;
    logic                  i_valid;
    logic                  i_block_lock;
    logic [NB_BLOCK-1:0]   i_data;
    logic [NB_AM-1:0]      i_compare_mask;
    logic [NB_THR-1:0]     i_valid_thr;
    logic [NB_THR-1:0]     i_invalid_thr;
    logic [NB_BLOCK-1:0]   o_data;
    logic                  o_valid;
    logic                  o_am_strobe;
    logic                  o_am_lock;
    logic [NB_LANE_ID-1:0] o_lane_id;
    logic                  o_resync;
    logic [NB_RESYNC-1:0]  o_resync_count;
    logic [NB_ERR-1:0]     o_error_count;

    logic [NB_STIM-1:0]    stim_mem [0:STIM_DEPTH-1];
    int                    n_lines;
    int                    total_cycles;
    int                    cycle;
    int                    error_count;
    int                    check_count;
    int                    assert_fails;
    int unsigned           seed_dummy;
    logic                  stim_ready;
    logic [NB_BIP-1:0]     bip_model;               // parity since the last marker

    // expectations for the next check
    logic [NB_BLOCK-1:0]   exp_data;
    logic                  exp_valid;
    logic                  exp_strobe;
    logic                  exp_lock;
    logic [NB_LANE_ID-1:0] exp_lane;
    logic                  exp_resync;
    logic [NB_RESYNC-1:0]  exp_resync_count;
    logic [NB_ERR-1:0]     exp_error_count;

    am_lock_top u_am_lock_top
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_block_lock   (i_block_lock),
        .i_data         (i_data),
        .i_compare_mask (i_compare_mask),
        .i_valid_thr    (i_valid_thr),
        .i_invalid_thr  (i_invalid_thr),
        .o_data         (o_data),
        .o_valid        (o_valid),
        .o_am_strobe    (o_am_strobe),
        .o_am_lock      (o_am_lock),
        .o_lane_id      (o_lane_id),
        .o_resync       (o_resync),
        .o_resync_count (o_resync_count),
        .o_error_count  (o_error_count)
    );

    bind am_lock_top am_lock_asserts u_am_lock_asserts
    (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_valid     (o_valid),
        .i_am_strobe (o_am_strobe),
        .i_am_lock   (o_am_lock),
        .i_lane_id   (o_lane_id),
        .i_resync    (o_resync)
    );

    initial
    begin
        i_clock = 1'b0;
    end

    always #CLOCK_HALF i_clock = ~i_clock;

    // bit j of the payload goes to parity bit j mod 8
    function automatic logic [NB_BIP-1:0] payload_parity(input logic [NB_PAYLOAD-1:0] payload);
        logic [NB_BIP-1:0] par;
        par = '0;
        for (int j = 0; j < NB_PAYLOAD; j++)
        begin
            par[j % NB_BIP] = par[j % NB_BIP] ^ payload[j];
        end
        return par;
    endfunction

    task automatic check_outputs(input int at_cycle);
        check_count++;
        if (o_data !== exp_data)
        begin
            error_count++;
            $display("ERROR o_data cycle %0d: got %h expected %h", at_cycle, o_data, exp_data);
        end
        if (o_valid !== exp_valid)
        begin
            error_count++;
            $display("ERROR o_valid cycle %0d: got %h expected %h", at_cycle, o_valid, exp_valid);
        end
        if (o_am_strobe !== exp_strobe)
        begin
            error_count++;
            $display("ERROR o_am_strobe cycle %0d: got %h expected %h",
                     at_cycle, o_am_strobe, exp_strobe);
        end
        if (o_am_lock !== exp_lock)
        begin
            error_count++;
            $display("ERROR o_am_lock cycle %0d: got %h expected %h",
                     at_cycle, o_am_lock, exp_lock);
        end
        if (o_lane_id !== exp_lane)
        begin
            error_count++;
            $display("ERROR o_lane_id cycle %0d: got %h expected %h",
                     at_cycle, o_lane_id, exp_lane);
        end
        if (o_resync !== exp_resync)
        begin
            error_count++;
            $display("ERROR o_resync cycle %0d: got %h expected %h",
                     at_cycle, o_resync, exp_resync);
        end
        if (o_resync_count !== exp_resync_count)
        begin
            error_count++;
            $display("ERROR o_resync_count cycle %0d: got %h expected %h",
                     at_cycle, o_resync_count, exp_resync_count);
        end
        if (o_error_count !== exp_error_count)
        begin
            error_count++;
            $display("ERROR o_error_count cycle %0d: got %h expected %h",
                     at_cycle, o_error_count, exp_error_count);
        end
    endtask

    task automatic drive_cycle(input logic [NB_STIM-1:0] line);
        logic [3:0]        mode;
        logic              is_marker;
        pcs_block_t        blk;
        logic [NB_BIP-1:0] bip;
        mode      = line[159:156];
        is_marker = (mode == MODE_AM) || (mode == MODE_AM_BAD);
        blk       = line[97:32];
        if (mode == MODE_IDLE)
        begin
            blk.raw.sh      = SH_DATA;
            blk.raw.payload = {$urandom(), $urandom()};
        end
        else if (is_marker)
        begin
            bip         = (mode == MODE_AM_BAD) ? (bip_model ^ BIP_FLIP) : bip_model;
            blk.am.bip3 = bip;
            blk.am.bip7 = ~bip;
        end
        i_valid        = line[152];
        i_block_lock   = line[148];
        i_compare_mask = line[147:100];
        i_data         = blk;
        if (line[152])
        begin
            if (is_marker)
            begin
                bip_model = '0;                     // new parity period
            end
            else
            begin
                bip_model = bip_model ^ payload_parity(blk.raw.payload);
            end
        end
        exp_data         = blk;
        exp_valid        = line[152];
        exp_lock         = line[28];
        exp_lane         = line[25:24];
        exp_resync       = (line[23:16] != exp_resync_count);   // pulse on each count step
        exp_resync_count = line[23:16];
        exp_error_count  = line[15:0];
        exp_strobe       = line[152] && line[28] && is_marker;
    endtask

    // watchdog, sized from the stimulus length
    initial
    begin
        longint timeout_ns;
        wait (stim_ready === 1'b1);
        timeout_ns = longint'(total_cycles + RESET_CYCLES + 2) * CLOCK_PERIOD * 4;
        #(timeout_ns);
        $display("timeout: stimulus playback did not finish within %0d ns", timeout_ns);
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        i_reset          = 1'b1;
        i_valid          = 1'b0;
        i_block_lock     = 1'b0;
        i_data           = '0;
        i_compare_mask   = '0;
        i_valid_thr      = NB_THR'(2);
        i_invalid_thr    = NB_THR'(2);
        error_count      = 0;
        check_count      = 0;
        cycle            = 0;
        bip_model        = '0;
        exp_data         = '0;
        exp_valid        = 1'b0;
        exp_strobe       = 1'b0;
        exp_lock         = 1'b0;
        exp_lane         = '0;
        exp_resync       = 1'b0;
        exp_resync_count = '0;
        exp_error_count  = '0;
        stim_ready       = 1'b0;
        seed_dummy       = $urandom(23);
        $readmemh("dv/am_lock_stim.hex", stim_mem);
        n_lines      = 0;
        total_cycles = 0;
        while ((n_lines < STIM_DEPTH) && !$isunknown(stim_mem[n_lines]))
        begin
            total_cycles += int'(stim_mem[n_lines][167:160]);
            n_lines++;
        end
        if (n_lines == 0)
        begin
            error_count++;
            $display("stimulus file is missing or holds no lines");
        end
        stim_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clock);
        @(negedge i_clock);
        i_reset = 1'b0;
        for (int line_idx = 0; line_idx < n_lines; line_idx++)
        begin
            for (int rep_idx = 0; rep_idx < int'(stim_mem[line_idx][167:160]); rep_idx++)
            begin
                check_outputs(cycle);               // result of the previous block
                drive_cycle(stim_mem[line_idx]);
                cycle++;
                @(negedge i_clock);
            end
        end
        check_outputs(cycle);
        assert_fails = u_am_lock_top.u_am_lock_asserts.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 check_count, error_count, assert_fails);
        if ((error_count == 0) && (assert_fails == 0))
        begin
            $display("All tests passed");
        end
        else
        begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/pcs_block_pkg.sv
design/am_lock_pkg.sv
design/am_match_decoder.sv
design/am_lock_fsm.sv
design/bip_error_checker.sv
design/am_lock_top.sv
dv/am_lock_asserts.sv
dv/am_lock_tb.sv

// ==== dv/am_lock_stim.hex ====
// rep mode valid block_lock compare_mask data | exp lock lane resync_count error_count
// mode 0 data as written, 1 random idle, 2 marker with bip3/bip7 filled in, 3 marker bad bip3
03_1_1_1_000000_000000_0_000000_00_000000_00_0_0_00_0000
01_2_1_1_000000_000000_2_594BE8_00_A6B417_00_0_2_00_0000
07_1_1_1_000000_000000_0_000000_00_000000_00_0_2_00_0000
01_2_1_1_000000_000000_2_594BE8_00_A6B417_00_1_2_00_0000
07_1_1_1_000000_000000_0_000000_00_000000_00_1_2_00_0000
01_3_1_1_000000_000000_2_594BE8_00_A6B417_00_1_2_00_0001
07_1_1_1_000000_000000_0_000000_00_000000_00_1_2_00_0001
01_2_1_1_000000_000000_2_594BE8_00_A6B417_00_1_2_00_0001
07_1_1_1_000000_000000_0_000000_00_000000_00_1_2_00_0001
01_1_1_1_000000_000000_0_000000_00_000000_00_1_2_00_0001
07_1_1_1_000000_000000_0_000000_00_000000_00_1_2_00_0001
01_1_1_1_000000_000000_0_000000_00_000000_00_0_2_01_0000
02_1_1_1_000000_000000_0_000000_00_000000_00_0_2_01_0000
01_2_1_1_000000_000000_2_9D718E_00_628E71_00_0_1_01_0000
07_1_1_1_000000_000000_0_000000_00_000000_00_0_1_01_0000
01_0_1_1_000000_000000_2_4D957B_00_B26A84_00_0_1_01_0000
07_1_1_1_000000_000000_0_000000_00_000000_00_0_1_01_0000
01_2_1_1_000000_000000_2_9D718E_00_628E71_00_0_1_01_0000
07_1_1_1_000000_000000_0_000000_00_000000_00_0_1_01_0000
01_2_1_1_0000FF_0000FF_2_9D7171_00_628E8E_00_1_1_01_0000
07_1_1_1_000000_000000_0_000000_00_000000_00_1_1_01_0000
01_0_1_1_000000_000000_2_9D7171_00_628E8E_00_1_1_01_0000
07_1_1_1_000000_000000_0_000000_00_000000_00_1_1_01_0000
01_2_1_1_000000_000000_2_9D718E_00_628E71_00_1_1_01_0000
01_1_1_0_000000_000000_0_000000_00_000000_00_0_1_02_0000
02_1_0_1_000000_000000_0_000000_00_000000_00_0_1_02_0000
02_1_1_1_000000_000000_0_000000_00_000000_00_0_1_02_0000
